/* hdl/pcie_hdr_pkg.sv */
// Simplified TLP header layout
package pcie_hdr_pkg;

  // Every stream moves one 64-bit flit per transfer
  localparam int FLIT_W = 64;

  // The fmt_type byte sits at the top of the first flit
  localparam int FMT_W   = 8;
  localparam int FMT_LSB = 56;

  // Tag field is wide enough for 10-bit tags even though only 8 are used
  localparam int TAG_LSB     = 40;
  localparam int TAG_FIELD_W = 10;

  // Final-completion flag in a completion header
  localparam int FC_BIT = 39;

  // Memory read requests, 32-bit and 64-bit address forms
  localparam logic [FMT_W-1:0] FMT_MRD32 = 8'h00;
  localparam logic [FMT_W-1:0] FMT_MRD64 = 8'h20;
  // Completion with data
  localparam logic [FMT_W-1:0] FMT_CPLD  = 8'h4A;

  typedef logic [FLIT_W-1:0] flit_t;

endpackage

/* hdl/tag_cfg_pkg.sv */
// Tag space configuration
package tag_cfg_pkg;

  // Number of requester streams sharing the pool
  localparam int N_TX_PORTS = 2;

  // Requesters may use any 8-bit tag
  localparam int AFU_NUM_TAGS = 256;
  localparam int AFU_TAG_W    = $clog2(AFU_NUM_TAGS);

  // Tags actually issued to the host come from a smaller pool
  localparam int SS_NUM_TAGS = 16;
  localparam int SS_TAG_W    = $clog2(SS_NUM_TAGS);

  // A single port still needs a one-bit index
  localparam int PORT_IDX_W = (N_TX_PORTS > 1) ? $clog2(N_TX_PORTS) : 1;

  // Tag as seen by the requester
  typedef logic [AFU_TAG_W-1:0] afu_tag_t;

  // Tag as seen on the link
  typedef logic [SS_TAG_W-1:0] ss_tag_t;

endpackage

/* hdl/tag_pool.sv */
// Shared free tag pool
module tag_pool import tag_cfg_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  // Consume alloc_tag this cycle
  input  logic    alloc,
  output logic    alloc_ready,
  output ss_tag_t alloc_tag,
  // Return a tag once its final completion has been seen
  input  logic    free_valid,
  input  ss_tag_t free_tag
);

  // One bit per pool tag, set while a read is outstanding on it
  logic [SS_NUM_TAGS-1:0] busy;

  // At least one tag is still free
  assign alloc_ready = ~&busy;

  // Priority search for the lowest free index
  // Scanning downwards lets the last match win, which is the lowest one
  always_comb begin
    alloc_tag = '0;
    for (int i = SS_NUM_TAGS - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        alloc_tag = ss_tag_t'(i);
      end
    end
  end

  // Busy bits change at the clock edge, so a new tag is busy from the next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // All tags start out free
      busy <= '0;
    end else begin
      // The freed tag is always busy, so it never matches the tag being handed out
      if (free_valid) begin
        busy[free_tag] <= 1'b0;
      end
      if (alloc) begin
        busy[alloc_tag] <= 1'b1;
      end
    end
  end

endmodule

/* hdl/tag_store.sv */
// Original tag map-back memory
module tag_store import tag_cfg_pkg::*; (
  input  logic     clk,
  // Write port, used when a read request is granted a pool tag
  input  logic     we,
  input  ss_tag_t  waddr,
  input  afu_tag_t wdata,
  // Read port, used by the completion path
  input  ss_tag_t  raddr,
  output afu_tag_t rdata
);

  // One entry per pool tag holding the requester's own tag
  afu_tag_t mem [SS_NUM_TAGS];

  // Entry is captured on the same edge that marks the pool tag busy
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Asynchronous read so the completion header is rewritten in the same cycle
  assign rdata = mem[raddr];

endmodule

/* hdl/tx_read_remap.sv */
// Per-port read tag substitution
module tx_read_remap import pcie_hdr_pkg::*, tag_cfg_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // Stream from the requester
  input  logic     tx_in_valid,
  input  flit_t    tx_in_data,
  input  logic     tx_in_last,
  output logic     tx_in_ready,
  // Stream towards the host
  output logic     tx_out_valid,
  output flit_t    tx_out_data,
  output logic     tx_out_last,
  input  logic     tx_out_ready,
  // Handshake with the arbiter and the pool
  output logic     read_req,
  input  logic     grant,
  input  ss_tag_t  alloc_tag,
  output afu_tag_t orig_tag
);

  // High while the next flit is the first flit of a packet
  logic             sop;
  logic [FMT_W-1:0] fmt;
  // A memory read header is waiting at the input
  logic             is_read;

  assign fmt     = tx_in_data[FMT_LSB +: FMT_W];
  assign is_read = sop & tx_in_valid & ((fmt == FMT_MRD32) | (fmt == FMT_MRD64));

  // Only ask for a tag when the flit could leave in this cycle
  // This way a stalled read never ties up a pool tag
  assign read_req = is_read & tx_out_ready;

  // Read starts wait for a grant, everything else flows straight through
  assign tx_out_valid = is_read ? (tx_in_valid & grant) : tx_in_valid;
  assign tx_in_ready  = is_read ? (tx_out_ready & grant) : tx_out_ready;
  assign tx_out_last  = tx_in_last;

  // Requester tag to be saved in the map-back memory
  assign orig_tag = tx_in_data[TAG_LSB +: AFU_TAG_W];

  // Replace the tag field of a read header with the zero-extended pool tag
  always_comb begin
    tx_out_data = tx_in_data;
    if (is_read) begin
      tx_out_data[TAG_LSB +: TAG_FIELD_W] = {{(TAG_FIELD_W - SS_TAG_W){1'b0}}, alloc_tag};
    end
  end

  // Next start of packet follows the last flit of the current one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sop <= 1'b1;
    end else if (tx_in_valid && tx_in_ready) begin
      sop <= tx_in_last;
    end
  end

endmodule

/* hdl/read_arbiter.sv */
// Round-robin read grant
module read_arbiter import tag_cfg_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // One request per port holding a read header
  input  logic [N_TX_PORTS-1:0] req,
  output logic [N_TX_PORTS-1:0] grant,
  output logic [PORT_IDX_W-1:0] grant_idx,
  // Pool has a free tag
  input  logic                  alloc_ready
);

  // Port with the highest priority in this cycle
  logic [PORT_IDX_W-1:0] ptr;

  // Walk the ports starting at the pointer and take the first requester
  always_comb begin
    int   idx;
    logic found;
    grant     = '0;
    grant_idx = '0;
    found     = 1'b0;
    idx       = 0;
    for (int k = 0; k < N_TX_PORTS; k++) begin
      idx = (int'(ptr) + k) % N_TX_PORTS;
      // Without a free tag nobody is granted
      if (alloc_ready && req[idx] && !found) begin
        found          = 1'b1;
        grant[idx]     = 1'b1;
        grant_idx      = PORT_IDX_W'(idx);
      end
    end
  end

  // Priority moves to the port just after the winner
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (|grant) begin
      if (int'(grant_idx) == N_TX_PORTS - 1) begin
        ptr <= '0;
      end else begin
        ptr <= grant_idx + 1'b1;
      end
    end
  end

endmodule

/* hdl/rx_cpl_restore.sv */
// Completion tag restore
module rx_cpl_restore import pcie_hdr_pkg::*, tag_cfg_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // Stream from the host
  input  logic     rx_in_valid,
  input  flit_t    rx_in_data,
  input  logic     rx_in_last,
  output logic     rx_in_ready,
  // Stream towards the requesters
  output logic     rx_out_valid,
  output flit_t    rx_out_data,
  output logic     rx_out_last,
  input  logic     rx_out_ready,
  // Lookup into the map-back memory
  output ss_tag_t  lookup_tag,
  input  afu_tag_t orig_tag,
  // Release of a pool tag, one cycle after the final completion
  output logic     free_valid,
  output ss_tag_t  free_tag
);

  // High while the next flit starts a packet
  logic             sop;
  logic [FMT_W-1:0] fmt;
  // First flit of a completion with data is at the input
  logic             is_cpl;

  assign fmt    = rx_in_data[FMT_LSB +: FMT_W];
  assign is_cpl = sop & rx_in_valid & (fmt == FMT_CPLD);

  // Pool tags only occupy the low bits of the tag field
  assign lookup_tag = rx_in_data[TAG_LSB +: SS_TAG_W];

  // The receive path never stalls on its own
  assign rx_in_ready  = rx_out_ready;
  assign rx_out_valid = rx_in_valid;
  assign rx_out_last  = rx_in_last;

  // Put the requester's tag back into the completion header
  always_comb begin
    rx_out_data = rx_in_data;
    if (is_cpl) begin
      rx_out_data[TAG_LSB +: TAG_FIELD_W] = {{(TAG_FIELD_W - AFU_TAG_W){1'b0}}, orig_tag};
    end
  end

  // A split completion keeps its tag until the final piece has gone through
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      free_valid <= 1'b0;
    end else begin
      free_valid <= is_cpl & rx_out_ready & rx_in_data[FC_BIT];
    end
  end

  // Tag to release, only looked at while free_valid is high
  always_ff @(posedge clk) begin
    free_tag <= lookup_tag;
  end

  // Start of packet follows each transferred last flit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sop <= 1'b1;
    end else if (rx_in_valid && rx_in_ready) begin
      sop <= rx_in_last;
    end
  end

endmodule

/* hdl/tag_remap.sv */
// Read tag remapper top level
module tag_remap import pcie_hdr_pkg::*, tag_cfg_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // Requester side transmit streams, one lane per port
  input  logic [N_TX_PORTS-1:0] tx_in_valid,
  input  flit_t                 tx_in_data [N_TX_PORTS],
  input  logic [N_TX_PORTS-1:0] tx_in_last,
  output logic [N_TX_PORTS-1:0] tx_in_ready,
  // Host side transmit streams
  output logic [N_TX_PORTS-1:0] tx_out_valid,
  output flit_t                 tx_out_data [N_TX_PORTS],
  output logic [N_TX_PORTS-1:0] tx_out_last,
  input  logic [N_TX_PORTS-1:0] tx_out_ready,
  // Completion stream from the host
  input  logic                  rx_in_valid,
  input  flit_t                 rx_in_data,
  input  logic                  rx_in_last,
  output logic                  rx_in_ready,
  // Completion stream back to the requesters
  output logic                  rx_out_valid,
  output flit_t                 rx_out_data,
  output logic                  rx_out_last,
  input  logic                  rx_out_ready
);

  logic                  alloc_ready;
  ss_tag_t               alloc_tag;
  logic                  alloc;
  logic [N_TX_PORTS-1:0] read_req;
  logic [N_TX_PORTS-1:0] grant;
  logic [PORT_IDX_W-1:0] grant_idx;
  afu_tag_t              orig_tag [N_TX_PORTS];
  ss_tag_t               lookup_tag;
  afu_tag_t              restore_tag;
  logic                  free_valid;
  ss_tag_t               free_tag;

  // Every grant consumes the tag currently offered by the pool
  assign alloc = |grant;

  tag_pool pool (
    .clk, .rst_n, .alloc, .alloc_ready, .alloc_tag, .free_valid, .free_tag
  );

  // The winning port's own tag is saved under the new pool tag
  tag_store store (
    .clk, .we(alloc), .waddr(alloc_tag), .wdata(orig_tag[grant_idx]),
    .raddr(lookup_tag), .rdata(restore_tag)
  );

  for (genvar p = 0; p < N_TX_PORTS; p++) begin : g_tx
    tx_read_remap remap (
      .clk, .rst_n,
      .tx_in_valid(tx_in_valid[p]), .tx_in_data(tx_in_data[p]),
      .tx_in_last(tx_in_last[p]), .tx_in_ready(tx_in_ready[p]),
      .tx_out_valid(tx_out_valid[p]), .tx_out_data(tx_out_data[p]),
      .tx_out_last(tx_out_last[p]), .tx_out_ready(tx_out_ready[p]),
      .read_req(read_req[p]), .grant(grant[p]),
      .alloc_tag, .orig_tag(orig_tag[p])
    );
  end

  read_arbiter arb (
    .clk, .rst_n, .req(read_req), .grant, .grant_idx, .alloc_ready
  );

  rx_cpl_restore restore (
    .clk, .rst_n,
    .rx_in_valid, .rx_in_data, .rx_in_last, .rx_in_ready,
    .rx_out_valid, .rx_out_data, .rx_out_last, .rx_out_ready,
    .lookup_tag, .orig_tag(restore_tag), .free_valid, .free_tag
  );

endmodule

/* tests/tag_remap_tests.svh */
// Directed tag remapper tests
`ifndef TAG_REMAP_TESTS_SVH
`define TAG_REMAP_TESTS_SVH

// Single-flit read whose output must carry the expected pool tag
task automatic send_read(input int p, input int exp_tag, input string name,
                         output afu_tag_t orig);
  flit_t       hdr;
  flit_t       out;
  logic [31:0] pick;
  hdr = rand_flit();
  pick = next_rand();
  hdr[FMT_LSB +: FMT_W] = pick[31] ? FMT_MRD64 : FMT_MRD32;
  orig = hdr[TAG_LSB +: AFU_TAG_W];
  send_tx(p, hdr, 1'b1, name, out);
  check(name, with_tag(hdr, exp_tag), out);
endtask

// Two-flit CplD whose header tag is restored and whose data flit passes untouched
task automatic send_completion(input int tag, input logic fc, input int orig,
                               input string name);
  flit_t hdr;
  flit_t data;
  flit_t out;
  hdr = rand_flit();
  hdr[FMT_LSB +: FMT_W] = FMT_CPLD;
  hdr[TAG_LSB +: TAG_FIELD_W] = TAG_FIELD_W'(tag);
  hdr[FC_BIT] = fc;
  data = rand_flit();
  send_rx(hdr, 1'b0, name, out);
  check({name, " header"}, with_tag(hdr, orig), out);
  send_rx(data, 1'b1, name, out);
  check({name, " data"}, data, out);
endtask

task automatic write_passthrough();
  flit_t hdr;
  flit_t data;
  flit_t out;
  apply_reset();
  for (int p = 0; p < N_TX_PORTS; p++) begin
    hdr = rand_flit();
    // MWr32 and MWr64 are not read codes
    hdr[FMT_LSB +: FMT_W] = (p == 0) ? 8'h40 : 8'h60;
    data = rand_flit();
    send_tx(p, hdr, 1'b0, "write header", out);
    check("write header", hdr, out);
    send_tx(p, data, 1'b1, "write data", out);
    check("write data", data, out);
  end
endtask

task automatic sequential_tags();
  afu_tag_t orig;
  apply_reset();
  for (int i = 0; i < 6; i++) begin
    send_read(0, i, "sequential read", orig);
  end
endtask

task automatic completion_restore();
  afu_tag_t origs [SS_NUM_TAGS];
  afu_tag_t extra;
  apply_reset();
  for (int i = 0; i < 4; i++) begin
    send_read(0, i, "restore setup read", origs[i]);
  end
  // Tag 2 stays busy after a partial completion, so the next read gets 4
  send_completion(2, 1'b0, origs[2], "restore non-final");
  wait_cycles(2);
  send_read(0, 4, "read after non-final", extra);
  send_completion(2, 1'b1, origs[2], "restore final");
  wait_cycles(2);
  send_read(0, 2, "read after final", extra);
endtask

task automatic pool_exhaustion();
  afu_tag_t origs [SS_NUM_TAGS];
  flit_t    hdr;
  flit_t    out;
  apply_reset();
  for (int i = 0; i < SS_NUM_TAGS; i++) begin
    send_read(0, i, "exhaust fill", origs[i]);
  end
  hdr = rand_flit();
  hdr[FMT_LSB +: FMT_W] = FMT_MRD32;
  drive_tx(0, hdr, 1'b1);
  hold_check(0, 20, "exhaust hold");
  send_completion(5, 1'b1, origs[5], "exhaust free");
  await_tx(0, "exhaust accept", out);
  check("exhaust accept", with_tag(hdr, 5), out);
endtask

task automatic dual_port_reads();
  flit_t hdr [N_TX_PORTS];
  flit_t out [N_TX_PORTS];
  int    exp_tag [N_TX_PORTS];
  apply_reset();
  for (int p = 0; p < N_TX_PORTS; p++) begin
    hdr[p] = rand_flit();
    hdr[p][FMT_LSB +: FMT_W] = FMT_MRD64;
    drive_tx(p, hdr[p], 1'b1);
  end
  fork
    await_tx(0, "dual port 0", out[0]);
    await_tx(1, "dual port 1", out[1]);
  join
  // Whichever port wins the first grant takes tag 0 and the other takes tag 1
  exp_tag[0] = (out[0][TAG_LSB +: TAG_FIELD_W] == '0) ? 0 : 1;
  exp_tag[1] = 1 - exp_tag[0];
  for (int p = 0; p < N_TX_PORTS; p++) begin
    check("dual port header", with_tag(hdr[p], exp_tag[p]), out[p]);
  end
  for (int p = 0; p < N_TX_PORTS; p++) begin
    send_completion(exp_tag[p], 1'b1, hdr[p][TAG_LSB +: AFU_TAG_W], "dual port completion");
  end
endtask

task automatic stalled_read();
  afu_tag_t first;
  flit_t    hdr;
  flit_t    out;
  apply_reset();
  send_read(0, 0, "stall setup read", first);
  tx_out_ready[0] = 1'b0;
  hdr = rand_flit();
  hdr[FMT_LSB +: FMT_W] = FMT_MRD64;
  drive_tx(0, hdr, 1'b1);
  hold_check(0, 10, "stall hold");
  tx_out_ready[0] = 1'b1;
  await_tx(0, "stall release", out);
  check("stall release", with_tag(hdr, 1), out);
endtask

`endif

/* tests/tag_remap_tb.sv */
// Read tag remapper testbench
module tag_remap_tb import pcie_hdr_pkg::*, tag_cfg_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // Longest wait for any handshake, in clock cycles
  localparam int TIMEOUT = 200;

  logic                  clk;
  logic                  rst_n;
  logic [N_TX_PORTS-1:0] tx_in_valid;
  flit_t                 tx_in_data [N_TX_PORTS];
  logic [N_TX_PORTS-1:0] tx_in_last;
  logic [N_TX_PORTS-1:0] tx_in_ready;
  logic [N_TX_PORTS-1:0] tx_out_valid;
  flit_t                 tx_out_data [N_TX_PORTS];
  logic [N_TX_PORTS-1:0] tx_out_last;
  logic [N_TX_PORTS-1:0] tx_out_ready;
  logic                  rx_in_valid;
  flit_t                 rx_in_data;
  logic                  rx_in_last;
  logic                  rx_in_ready;
  logic                  rx_out_valid;
  flit_t                 rx_out_data;
  logic                  rx_out_last;
  logic                  rx_out_ready;

  int          checks;
  int          errors;
  logic [31:0] lcg_state;

  tag_remap dut0 (
    .clk, .rst_n,
    .tx_in_valid, .tx_in_data, .tx_in_last, .tx_in_ready,
    .tx_out_valid, .tx_out_data, .tx_out_last, .tx_out_ready,
    .rx_in_valid, .rx_in_data, .rx_in_last, .rx_in_ready,
    .rx_out_valid, .rx_out_data, .rx_out_last, .rx_out_ready
  );

  // 4 ns clock period
  always #2 clk = ~clk;

  // Inputs change half a nanosecond after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    wait_cycles(5);
    rst_n = 1'b1;
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic flit_t rand_flit();
    return {next_rand(), next_rand()};
  endfunction

  // Expected header after the tag field is rewritten, zero-extended
  function automatic flit_t with_tag(input flit_t f, input int tag);
    flit_t r;
    r = f;
    r[TAG_LSB +: TAG_FIELD_W] = TAG_FIELD_W'(tag);
    return r;
  endfunction

  task automatic check(input string name, input logic [FLIT_W-1:0] expected,
                       input logic [FLIT_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic drive_tx(input int p, input flit_t data, input logic last);
    tx_in_valid[p] = 1'b1;
    tx_in_data[p]  = data;
    tx_in_last[p]  = last;
  endtask

  // Outputs are sampled at the falling edge, the flit transfers at the next rising edge
  task automatic await_tx(input int p, input string name, output flit_t out);
    int n;
    n = 0;
    @(negedge clk);
    while (!tx_in_ready[p] && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!tx_in_ready[p]) begin
      errors++;
      $display("Timeout in %s: port %0d never accepted its flit", name, p);
    end
    check({name, " valid"}, 1'b1, tx_out_valid[p]);
    check({name, " last"}, tx_in_last[p], tx_out_last[p]);
    out = tx_out_data[p];
    next_cycle();
    tx_in_valid[p] = 1'b0;
  endtask

  task automatic send_tx(input int p, input flit_t data, input logic last,
                         input string name, output flit_t out);
    drive_tx(p, data, last);
    await_tx(p, name, out);
  endtask

  // The flit already on the port must stay blocked for the whole window
  task automatic hold_check(input int p, input int cycles, input string name);
    repeat (cycles) begin
      @(negedge clk);
      check({name, " ready"}, 1'b0, tx_in_ready[p]);
      check({name, " valid"}, 1'b0, tx_out_valid[p]);
    end
    next_cycle();
  endtask

  task automatic send_rx(input flit_t data, input logic last, input string name,
                         output flit_t out);
    int n;
    n = 0;
    rx_in_valid = 1'b1;
    rx_in_data  = data;
    rx_in_last  = last;
    @(negedge clk);
    while (!rx_in_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!rx_in_ready) begin
      errors++;
      $display("Timeout in %s: receive stream never accepted its flit", name);
    end
    check({name, " valid"}, 1'b1, rx_out_valid);
    check({name, " last"}, last, rx_out_last);
    out = rx_out_data;
    next_cycle();
    rx_in_valid = 1'b0;
  endtask

  `include "tag_remap_tests.svh"

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    tx_in_valid  = '0;
    tx_in_last   = '0;
    tx_out_ready = '1;
    rx_in_valid  = 1'b0;
    rx_in_data   = '0;
    rx_in_last   = 1'b0;
    rx_out_ready = 1'b1;
    for (int p = 0; p < N_TX_PORTS; p++) begin
      tx_in_data[p] = '0;
    end
    lcg_state = 32'h601e_7979;
    checks    = 0;
    errors    = 0;
    write_passthrough();
    sequential_tags();
    completion_restore();
    pool_exhaustion();
    dual_port_reads();
    stalled_read();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+tests
hdl/pcie_hdr_pkg.sv
hdl/tag_cfg_pkg.sv
hdl/tag_pool.sv
hdl/tag_store.sv
hdl/tx_read_remap.sv
hdl/read_arbiter.sv
hdl/rx_cpl_restore.sv
hdl/tag_remap.sv
tests/tag_remap_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the tag remapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  -f tb.f --top-module tag_remap_tb

./obj_dir/Vtag_remap_tb | tee sim.log

# The run passes only if the testbench printed its pass line
grep -q "^Verification passed$" sim.log
